// File: compile.f
+incdir+include
hw/a2glue_bus_pkg.sv
hw/a2glue_video_pkg.sv
hw/card_response_arbiter.sv
hw/audio_mixer.sv
hw/video_source_select.sv
hw/border_palette.sv
hw/vdp_raster_counter.sv
hw/status_panel.sv
hw/a2_card_glue.sv
sim/tb_a2_card_glue.sv

// File: Bender.yml
package:
  name: a2_card_glue

sources:
  - files:
      - hw/a2glue_bus_pkg.sv
      - hw/a2glue_video_pkg.sv
      - hw/card_response_arbiter.sv
      - hw/audio_mixer.sv
      - hw/video_source_select.sv
      - hw/border_palette.sv
      - hw/vdp_raster_counter.sv
      - hw/status_panel.sv
      - hw/a2_card_glue.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_a2_card_glue.sv

// File: include/tb_glue_model.svh
`ifndef TB_GLUE_MODEL_SVH
`define TB_GLUE_MODEL_SVH

task automatic compare_values(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        $display("*** FAILED ***");
        $fatal(1, "Mismatch on %s", what);
    end
endtask

// Start from the bus value and let each answering card override in rising priority order
function automatic logic [7:0] read_data_model(input card_resp_t ssc, input card_resp_t ssp,
                                               input card_resp_t mb, input logic [7:0] bus);
    logic [7:0] d;
    d = bus;
    if (mb.rd_en) begin
        d = mb.data;
    end
    if (ssp.rd_en) begin
        d = ssp.data;
    end
    if (ssc.rd_en) begin
        d = ssc.data;  // Serial card has the last word
    end
    return d;
endfunction

// One channel of the mixer as plain integer arithmetic
function automatic logic [AUDIO_W-1:0] mix_model(input logic speaker,
                                                 input logic [CARD_AUDIO_W-1:0] card_a,
                                                 input logic [CARD_AUDIO_W-1:0] card_b,
                                                 input logic [AUDIO_W-1:0] glu);
    int unsigned sum;
    sum = glu;
    if (speaker) begin
        sum += 4096;  // Bit 12
    end
    sum += card_a * 8;
    sum += card_b * 8;
    return AUDIO_W'(sum % (1 << AUDIO_W));
endfunction

// RGB444 nibble goes to the top of each 6-bit field
function automatic rgb666_t widen_model(input logic [11:0] rgb444);
    rgb666_t w;
    w.r = 6'(rgb444[11:8]) << 2;
    w.g = 6'(rgb444[7:4]) << 2;
    w.b = 6'(rgb444[3:0]) << 2;
    return w;
endfunction

// One clock of the VDP horizontal counter
task automatic step_raster_model(input logic hsync, inout int x, inout int div);
    if (hsync) begin
        x   = 0;
        div = 0;
    end else begin
        if (div == VDP_DIV - 1 && x < VDP_HMAX) begin
            x++;
        end
        div = (div + 1) % VDP_DIV;
    end
endtask

`endif

// File: sim/tb_a2_card_glue.sv
module tb_a2_card_glue;

    import a2glue_bus_pkg::*;
    import a2glue_video_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DLY    = 5;   // After the rising edge
    localparam int CHECK_DLY    = 85;  // Ten units before the next edge
    localparam int RAND_SEED    = 23305;

    localparam int N_CARDS  = 200;
    localparam int N_AUDIO  = 200;
    localparam int N_VIDEO  = 400;
    localparam int N_BORDER = 200;
    localparam int N_PANEL  = 600;
    localparam int N_HOLD   = 3600;  // Long enough for the raster to saturate
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + N_CARDS + N_AUDIO + N_VIDEO
                                  + N_BORDER + N_PANEL + N_HOLD;
    localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    typedef enum int {PH_CARDS, PH_AUDIO, PH_VIDEO, PH_BORDER, PH_PANEL, PH_HOLD} phase_e;

    logic a2bus_if;
    logic rst_n;
    card_resp_t card_resp [NUM_CARDS];
    logic [7:0] bus_data;
    logic data_out_en;
    logic [7:0] data_out;
    logic irq_n;
    logic speaker;
    logic [CARD_AUDIO_W-1:0] ssp_audio;
    logic [CARD_AUDIO_W-1:0] mb_audio_l;
    logic [CARD_AUDIO_W-1:0] mb_audio_r;
    logic [AUDIO_W-1:0] glu_audio_l;
    logic [AUDIO_W-1:0] glu_audio_r;
    logic [AUDIO_W-1:0] audio_l;
    logic [AUDIO_W-1:0] audio_r;
    logic vsync;
    logic hsync;
    video_mode_t mode;
    fb_stream_t apple_fb;
    fb_stream_t vgc_fb;
    fb_stream_t fb;
    logic [FB_WIDTH_W-1:0] fb_width;
    logic [FB_HEIGHT_W-1:0] fb_height;
    fb_source_e source;
    logic sw_gs;
    rgb666_t border;
    logic [VDP_X_W-1:0] vdp_x;
    logic button;
    logic overlay_en;
    logic [4:0] led;

    // Model state valid at the check point of the current cycle
    logic [AUDIO_W-1:0] exp_audio_l;
    logic [AUDIO_W-1:0] exp_audio_r;
    fb_source_e exp_source;
    rgb666_t exp_border;
    int exp_x;
    int exp_div;
    logic exp_overlay;
    logic prev_button;
    logic [4:0] exp_led;

    `include "tb_glue_model.svh"

    a2_card_glue u_a2_card_glue (
        .a2bus_if(a2bus_if), .rst_n_i(rst_n),
        .card_resp_i(card_resp), .bus_data_i(bus_data),
        .data_out_en_o(data_out_en), .data_out_o(data_out), .irq_n_o(irq_n),
        .speaker_i(speaker), .ssp_audio_i(ssp_audio),
        .mb_audio_l_i(mb_audio_l), .mb_audio_r_i(mb_audio_r),
        .glu_audio_l_i(glu_audio_l), .glu_audio_r_i(glu_audio_r),
        .audio_l_o(audio_l), .audio_r_o(audio_r),
        .vsync_i(vsync), .hsync_i(hsync), .mode_i(mode),
        .apple_fb_i(apple_fb), .vgc_fb_i(vgc_fb), .fb_o(fb),
        .fb_width_o(fb_width), .fb_height_o(fb_height), .source_o(source),
        .sw_gs_i(sw_gs), .border_o(border), .vdp_x_o(vdp_x),
        .button_i(button), .overlay_en_o(overlay_en), .led_o(led)
    );

    initial a2bus_if = 1'b0;
    always #(CLK_PERIOD / 2) a2bus_if = ~a2bus_if;

    task automatic init_inputs();
        for (int i = 0; i < NUM_CARDS; i++) begin
            card_resp[i] = '{rd_en: 1'b0, data: 8'h00, irq_n: 1'b1};  // Idle card
        end
        bus_data    = '0;
        speaker     = 1'b0;
        ssp_audio   = '0;
        mb_audio_l  = '0;
        mb_audio_r  = '0;
        glu_audio_l = '0;
        glu_audio_r = '0;
        vsync       = 1'b0;
        hsync       = 1'b0;
        mode        = '0;
        apple_fb    = '0;
        vgc_fb      = '0;
        sw_gs       = 1'b0;
        button      = 1'b0;
    endtask

    task automatic reset_model();
        exp_audio_l = '0;
        exp_audio_r = '0;
        exp_source  = FB_SRC_APPLE;
        exp_border  = '0;
        exp_x       = 0;
        exp_div     = 0;
        exp_overlay = 1'b1;
        prev_button = 1'b0;
        exp_led     = 5'b11111;
    endtask

    task automatic randomize_inputs(input phase_e phase);
        vsync = 1'b0;  // Sync pulses only where a phase asks for them
        hsync = 1'b0;
        case (phase)
            PH_CARDS: begin
                for (int i = 0; i < NUM_CARDS; i++) begin
                    card_resp[i] = 10'($urandom());
                end
                bus_data = 8'($urandom());
            end
            PH_AUDIO: begin
                speaker     = 1'($urandom());
                ssp_audio   = CARD_AUDIO_W'($urandom());
                mb_audio_l  = CARD_AUDIO_W'($urandom());
                mb_audio_r  = CARD_AUDIO_W'($urandom());
                glu_audio_l = AUDIO_W'($urandom());
                glu_audio_r = AUDIO_W'($urandom());
            end
            PH_VIDEO: begin
                mode.shrg = 1'($urandom());
                vsync     = ($urandom_range(15, 0) == 0);  // Sparse frame boundaries
                apple_fb  = 20'($urandom());
                vgc_fb    = 20'($urandom());
            end
            PH_BORDER: begin
                mode.border = 4'($urandom());
                sw_gs       = 1'($urandom());
            end
            PH_PANEL: begin
                if ($urandom_range(3, 0) == 0) begin
                    button = ~button;
                end
                hsync = ($urandom_range(63, 0) == 0);
                mode  = 9'($urandom());
            end
            default: begin
                if ($urandom_range(7, 0) == 0) begin
                    button = ~button;
                end
            end
        endcase
    endtask

    task automatic check_reset_state();
        compare_values("overlay_en after reset", overlay_en, 1);
        compare_values("led after reset", led, 5'b11111);
        compare_values("vdp_x after reset", vdp_x, 0);
        compare_values("source after reset", source, FB_SRC_APPLE);
        compare_values("fb_width after reset", fb_width, 560);
        compare_values("fb_height after reset", fb_height, 192);
        compare_values("audio_l after reset", audio_l, 0);
        compare_values("audio_r after reset", audio_r, 0);
    endtask

    task automatic check_outputs();
        logic exp_en;
        logic exp_irq_n;
        logic [7:0] exp_data;
        exp_en    = card_resp[0].rd_en | card_resp[1].rd_en | card_resp[2].rd_en;
        exp_irq_n = card_resp[0].irq_n & card_resp[1].irq_n & card_resp[2].irq_n;
        exp_data  = read_data_model(card_resp[CARD_SSC], card_resp[CARD_SSP],
                                    card_resp[CARD_MB], bus_data);
        compare_values("data_out_en", data_out_en, exp_en);
        compare_values("data_out", data_out, exp_data);
        compare_values("irq_n", irq_n, exp_irq_n);
        compare_values("audio_l", audio_l, exp_audio_l);
        compare_values("audio_r", audio_r, exp_audio_r);
        compare_values("source", source, exp_source);
        compare_values("fb", fb, (exp_source == FB_SRC_VGC) ? vgc_fb : apple_fb);
        compare_values("fb_width", fb_width, (exp_source == FB_SRC_VGC) ? 640 : 560);
        compare_values("fb_height", fb_height, (exp_source == FB_SRC_VGC) ? 200 : 192);
        compare_values("border", border, exp_border);
        compare_values("vdp_x", vdp_x, exp_x);
        compare_values("overlay_en", overlay_en, exp_overlay);
        compare_values("led", led, exp_led);
    endtask

    // What the next rising edge captures from the inputs now on the pins
    task automatic advance_model();
        exp_audio_l = mix_model(speaker, ssp_audio, mb_audio_l, glu_audio_l);
        exp_audio_r = mix_model(speaker, ssp_audio, mb_audio_r, glu_audio_r);
        if (vsync) begin
            exp_source = mode.shrg ? FB_SRC_VGC : FB_SRC_APPLE;
        end
        exp_border = widen_model(BORDER_PALETTE[{sw_gs, mode.border}]);
        step_raster_model(hsync, exp_x, exp_div);
        if (button && !prev_button) begin
            exp_overlay = ~exp_overlay;
        end
        prev_button = button;
        exp_led     = ~{mode.text, mode.shrg, mode.hires, mode.ramwrt, mode.store80};
    endtask

    task automatic run_cycles(input phase_e phase, input int n);
        for (int c = 0; c < n; c++) begin
            @(posedge a2bus_if);
            #DRIVE_DLY;
            randomize_inputs(phase);
            #CHECK_DLY;
            check_outputs();
            advance_model();
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        init_inputs();
        reset_model();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge a2bus_if);
        #DRIVE_DLY;
        rst_n = 1'b1;
        #CHECK_DLY;
        check_reset_state();
        check_outputs();
        advance_model();

        run_cycles(PH_CARDS, N_CARDS);
        run_cycles(PH_AUDIO, N_AUDIO);
        run_cycles(PH_VIDEO, N_VIDEO);
        run_cycles(PH_BORDER, N_BORDER);
        run_cycles(PH_PANEL, N_PANEL);
        run_cycles(PH_HOLD, N_HOLD);

        // Any mismatch has already stopped the run
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: hw/a2_card_glue.sv
module a2_card_glue (
    input  logic                                            a2bus_if,
    input  logic                                            rst_n_i,
    // Slot card bus
    input  a2glue_bus_pkg::card_resp_t card_resp_i [a2glue_bus_pkg::NUM_CARDS],
    input  logic [7:0]                                      bus_data_i,
    output logic                                            data_out_en_o,
    output logic [7:0]                                      data_out_o,
    output logic                                            irq_n_o,
    // Audio sources
    input  logic                                            speaker_i,
    input  logic        [a2glue_bus_pkg::CARD_AUDIO_W-1:0]  ssp_audio_i,
    input  logic        [a2glue_bus_pkg::CARD_AUDIO_W-1:0]  mb_audio_l_i,
    input  logic        [a2glue_bus_pkg::CARD_AUDIO_W-1:0]  mb_audio_r_i,
    input  logic signed [a2glue_bus_pkg::AUDIO_W-1:0]       glu_audio_l_i,
    input  logic signed [a2glue_bus_pkg::AUDIO_W-1:0]       glu_audio_r_i,
    output logic signed [a2glue_bus_pkg::AUDIO_W-1:0]       audio_l_o,
    output logic signed [a2glue_bus_pkg::AUDIO_W-1:0]       audio_r_o,
    // Video
    input  logic                                            vsync_i,
    input  logic                                            hsync_i,
    input  a2glue_video_pkg::video_mode_t                   mode_i,
    input  a2glue_video_pkg::fb_stream_t                    apple_fb_i,
    input  a2glue_video_pkg::fb_stream_t                    vgc_fb_i,
    output a2glue_video_pkg::fb_stream_t                    fb_o,
    output logic [a2glue_video_pkg::FB_WIDTH_W-1:0]         fb_width_o,
    output logic [a2glue_video_pkg::FB_HEIGHT_W-1:0]        fb_height_o,
    output a2glue_video_pkg::fb_source_e                    source_o,
    input  logic                                            sw_gs_i,
    output a2glue_video_pkg::rgb666_t                       border_o,
    output logic [a2glue_video_pkg::VDP_X_W-1:0]            vdp_x_o,
    // Panel
    input  logic                                            button_i,
    output logic                                            overlay_en_o,
    output logic [4:0]                                      led_o
);

    card_response_arbiter u_card_response_arbiter (
        .card_resp_i  (card_resp_i),
        .bus_data_i   (bus_data_i),
        .data_out_en_o(data_out_en_o),
        .data_out_o   (data_out_o),
        .irq_n_o      (irq_n_o)
    );

    audio_mixer u_audio_mixer (
        .a2bus_if     (a2bus_if),
        .rst_n_i      (rst_n_i),
        .speaker_i    (speaker_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .glu_audio_l_i(glu_audio_l_i),
        .glu_audio_r_i(glu_audio_r_i),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o)
    );

    video_source_select u_video_source_select (
        .a2bus_if   (a2bus_if),
        .rst_n_i    (rst_n_i),
        .vsync_i    (vsync_i),
        .mode_i     (mode_i),
        .apple_fb_i (apple_fb_i),
        .vgc_fb_i   (vgc_fb_i),
        .fb_o       (fb_o),
        .fb_width_o (fb_width_o),
        .fb_height_o(fb_height_o),
        .source_o   (source_o)
    );

    // Border index comes straight from the mode flags
    border_palette u_border_palette (
        .a2bus_if    (a2bus_if),
        .rst_n_i     (rst_n_i),
        .sw_gs_i     (sw_gs_i),
        .border_idx_i(mode_i.border),
        .border_o    (border_o)
    );

    vdp_raster_counter u_vdp_raster_counter (
        .a2bus_if(a2bus_if),
        .rst_n_i (rst_n_i),
        .hsync_i (hsync_i),
        .vdp_x_o (vdp_x_o)
    );

    status_panel u_status_panel (
        .a2bus_if    (a2bus_if),
        .rst_n_i     (rst_n_i),
        .button_i    (button_i),
        .mode_i      (mode_i),
        .overlay_en_o(overlay_en_o),
        .led_o       (led_o)
    );

endmodule

// File: hw/status_panel.sv
module status_panel (
    input  logic                          a2bus_if,
    input  logic                          rst_n_i,
    input  logic                          button_i,
    input  a2glue_video_pkg::video_mode_t mode_i,
    output logic                          overlay_en_o,
    output logic [4:0]                    led_o
);

    import a2glue_video_pkg::*;

    logic button_q;
    logic button_rise;

    // Button is already debounced upstream
    assign button_rise = button_i & ~button_q;

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            button_q     <= 1'b0;
            overlay_en_o <= OVERLAY_ON_RESET;
            led_o        <= '1;  // All LEDs off
        end else begin
            button_q <= button_i;
            if (button_rise) begin
                overlay_en_o <= ~overlay_en_o;
            end
            // LEDs are active low
            led_o <= ~{mode_i.text, mode_i.shrg, mode_i.hires, mode_i.ramwrt, mode_i.store80};
        end
    end

endmodule

// File: hw/vdp_raster_counter.sv
module vdp_raster_counter (
    input  logic                                 a2bus_if,
    input  logic                                 rst_n_i,
    input  logic                                 hsync_i,
    output logic [a2glue_video_pkg::VDP_X_W-1:0] vdp_x_o
);

    import a2glue_video_pkg::*;

    localparam int DIV_W = $clog2(VDP_DIV);

    logic [DIV_W-1:0] div_q;

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            div_q   <= '0;
            vdp_x_o <= '0;
        end else if (hsync_i) begin
            div_q   <= '0;  // New Apple scanline
            vdp_x_o <= '0;
        end else begin
            div_q <= div_q + 1'b1;
            // Stops at the last raster position until the next hsync
            if (div_q == DIV_W'(VDP_DIV - 1) && vdp_x_o < VDP_HMAX) begin
                vdp_x_o <= vdp_x_o + 1'b1;
            end
        end
    end

endmodule

// File: hw/border_palette.sv
module border_palette (
    input  logic                      a2bus_if,
    input  logic                      rst_n_i,
    input  logic                      sw_gs_i,
    input  logic [3:0]                border_idx_i,
    output a2glue_video_pkg::rgb666_t border_o
);

    import a2glue_video_pkg::*;

    logic [$clog2(PALETTE_DEPTH)-1:0] pal_idx;
    logic [11:0]                      rgb444;

    // Upper half of the table holds the IIgs colours
    assign pal_idx = {sw_gs_i, border_idx_i};
    assign rgb444  = BORDER_PALETTE[pal_idx];

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            border_o <= '0;  // Black
        end else begin
            // Each nibble goes to the top of its 6-bit field
            border_o.r <= {rgb444[11:8], 2'b00};
            border_o.g <= {rgb444[7:4], 2'b00};
            border_o.b <= {rgb444[3:0], 2'b00};
        end
    end

endmodule

// File: hw/video_source_select.sv
module video_source_select (
    input  logic                                      a2bus_if,
    input  logic                                      rst_n_i,
    input  logic                                      vsync_i,
    input  a2glue_video_pkg::video_mode_t             mode_i,
    input  a2glue_video_pkg::fb_stream_t              apple_fb_i,
    input  a2glue_video_pkg::fb_stream_t              vgc_fb_i,
    output a2glue_video_pkg::fb_stream_t              fb_o,
    output logic [a2glue_video_pkg::FB_WIDTH_W-1:0]   fb_width_o,
    output logic [a2glue_video_pkg::FB_HEIGHT_W-1:0]  fb_height_o,
    output a2glue_video_pkg::fb_source_e              source_o
);

    import a2glue_video_pkg::*;

    fb_source_e source_q;

    // Only switch at a frame boundary so one frame never mixes sources
    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            source_q <= FB_SRC_APPLE;
        end else if (vsync_i) begin
            source_q <= mode_i.shrg ? FB_SRC_VGC : FB_SRC_APPLE;
        end
    end

    assign source_o = source_q;

    always_comb begin
        if (source_q == FB_SRC_VGC) begin
            fb_o        = vgc_fb_i;
            fb_width_o  = FB_VGC_WIDTH;
            fb_height_o = FB_VGC_HEIGHT;
        end else begin
            fb_o        = apple_fb_i;
            fb_width_o  = FB_APPLE_WIDTH;  // 280 doubled
            fb_height_o = FB_APPLE_HEIGHT;
        end
    end

endmodule

// File: hw/audio_mixer.sv
module audio_mixer (
    input  logic                                       a2bus_if,
    input  logic                                       rst_n_i,
    input  logic                                       speaker_i,
    input  logic        [a2glue_bus_pkg::CARD_AUDIO_W-1:0] ssp_audio_i,
    input  logic        [a2glue_bus_pkg::CARD_AUDIO_W-1:0] mb_audio_l_i,
    input  logic        [a2glue_bus_pkg::CARD_AUDIO_W-1:0] mb_audio_r_i,
    input  logic signed [a2glue_bus_pkg::AUDIO_W-1:0]      glu_audio_l_i,
    input  logic signed [a2glue_bus_pkg::AUDIO_W-1:0]      glu_audio_r_i,
    output logic signed [a2glue_bus_pkg::AUDIO_W-1:0]      audio_l_o,
    output logic signed [a2glue_bus_pkg::AUDIO_W-1:0]      audio_r_o
);

    import a2glue_bus_pkg::*;

    localparam int PAD_W = AUDIO_ALIGN_W - CARD_AUDIO_W;

    logic [AUDIO_ALIGN_W-1:0] spk_ext;
    logic [AUDIO_ALIGN_W-1:0] ssp_ext;
    logic [AUDIO_ALIGN_W-1:0] mb_l_ext;
    logic [AUDIO_ALIGN_W-1:0] mb_r_ext;
    logic [AUDIO_W-1:0]       common;  // Sources shared by both channels
    logic [AUDIO_W-1:0]       sum_l;
    logic [AUDIO_W-1:0]       sum_r;

    // Single-bit speaker sits at full scale of the aligned range
    assign spk_ext  = {speaker_i, {(AUDIO_ALIGN_W-1){1'b0}}};
    assign ssp_ext  = {ssp_audio_i, {PAD_W{1'b0}}};
    assign mb_l_ext = {mb_audio_l_i, {PAD_W{1'b0}}};
    assign mb_r_ext = {mb_audio_r_i, {PAD_W{1'b0}}};

    assign common = AUDIO_W'(spk_ext) + AUDIO_W'(ssp_ext);

    // Wraps modulo 2^16 on overflow
    assign sum_l = AUDIO_W'(glu_audio_l_i) + common + AUDIO_W'(mb_l_ext);
    assign sum_r = AUDIO_W'(glu_audio_r_i) + common + AUDIO_W'(mb_r_ext);

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= signed'(sum_l);
            audio_r_o <= signed'(sum_r);
        end
    end

endmodule

// File: hw/card_response_arbiter.sv
module card_response_arbiter (
    input  a2glue_bus_pkg::card_resp_t card_resp_i [a2glue_bus_pkg::NUM_CARDS],
    input  logic [7:0]                 bus_data_i,
    output logic                       data_out_en_o,
    output logic [7:0]                 data_out_o,
    output logic                       irq_n_o
);

    import a2glue_bus_pkg::*;

    // Any card answering the read claims the bus
    always_comb begin
        data_out_en_o = 1'b0;
        irq_n_o       = 1'b1;
        for (int i = 0; i < NUM_CARDS; i++) begin
            data_out_en_o = data_out_en_o | card_resp_i[i].rd_en;
            irq_n_o       = irq_n_o & card_resp_i[i].irq_n;  // Open-drain style AND
        end
    end

    // Fixed priority with the serial card on top
    always_comb begin
        if (card_resp_i[CARD_SSC].rd_en) begin
            data_out_o = card_resp_i[CARD_SSC].data;
        end else if (card_resp_i[CARD_SSP].rd_en) begin
            data_out_o = card_resp_i[CARD_SSP].data;
        end else if (card_resp_i[CARD_MB].rd_en) begin
            data_out_o = card_resp_i[CARD_MB].data;
        end else begin
            data_out_o = bus_data_i;  // Echo the bus when no card answers
        end
    end

endmodule

// File: hw/a2glue_video_pkg.sv
package a2glue_video_pkg;

    // Framebuffer dimensions per source
    localparam int FB_WIDTH_W  = 11;
    localparam int FB_HEIGHT_W = 10;

    localparam logic [FB_WIDTH_W-1:0]  FB_APPLE_WIDTH  = 11'd560;
    localparam logic [FB_HEIGHT_W-1:0] FB_APPLE_HEIGHT = 10'd192;
    localparam logic [FB_WIDTH_W-1:0]  FB_VGC_WIDTH    = 11'd640;  // Super Hi-Res
    localparam logic [FB_HEIGHT_W-1:0] FB_VGC_HEIGHT   = 10'd200;

    // VDP raster
    localparam int VDP_X_W = 10;
    localparam int VDP_DIV = 4;  // Clocks per horizontal step
    localparam logic [VDP_X_W-1:0] VDP_HMAX = 10'd856;

    // Status panel
    localparam logic OVERLAY_ON_RESET = 1'b1;

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } rgb666_t;

    typedef struct packed {
        logic    we;
        rgb666_t data;
        logic    vsync;
    } fb_stream_t;

    typedef enum logic {
        FB_SRC_APPLE = 1'b0,
        FB_SRC_VGC   = 1'b1
    } fb_source_e;

    // Soft-switch state seen by the video side
    typedef struct packed {
        logic       text;
        logic       shrg;
        logic       hires;
        logic       ramwrt;
        logic       store80;
        logic [3:0] border;
    } video_mode_t;

    // Border colours in RGB444 with the Apple II set before the IIgs set
    localparam int PALETTE_DEPTH = 32;
    localparam logic [11:0] BORDER_PALETTE [PALETTE_DEPTH] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e, 12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac, 12'h3c2, 12'hcd6, 12'h7ec, 12'hfff,
        12'h000, 12'hd03, 12'h009, 12'hd2d, 12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98, 12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

endpackage

// File: hw/a2glue_bus_pkg.sv
package a2glue_bus_pkg;

    // Slot cards on the glue bus
    localparam int NUM_CARDS = 3;

    // Audio widths
    localparam int AUDIO_W       = 16;  // Mixed signed sample
    localparam int CARD_AUDIO_W  = 10;  // Sprite and sound-effect card output
    localparam int AUDIO_ALIGN_W = 13;  // Common range for the unsigned sources

    // One card's answer to a bus read plus its interrupt line
    typedef struct packed {
        logic       rd_en;
        logic [7:0] data;
        logic       irq_n;  // Active low and wire-ANDed
    } card_resp_t;

    // Listed in priority order from the highest
    typedef enum logic [1:0] {
        CARD_SSC = 2'd0,  // Serial card
        CARD_SSP = 2'd1,  // Sprite card
        CARD_MB  = 2'd2   // Sound-effect card
    } card_id_e;

endpackage
